/* hw/term_pkg.sv */
package term_pkg;

	// horizontal timing in pixel clocks
	localparam logic [9:0] h_visible = 10'd640;
	localparam logic [9:0] h_front = 10'd16;
	localparam logic [9:0] h_sync = 10'd96;
	localparam logic [9:0] h_back = 10'd48;
	localparam logic [9:0] h_total = 10'd800;

	// vertical timing in lines
	localparam logic [9:0] v_visible = 10'd480;
	localparam logic [9:0] v_front = 10'd10;
	localparam logic [9:0] v_sync = 10'd2;
	localparam logic [9:0] v_back = 10'd33;
	localparam logic [9:0] v_total = 10'd525;

	localparam logic [6:0] grid_cols = 7'd71;
	localparam logic [4:0] grid_rows = 5'd30;
	localparam logic [3:0] cell_w = 4'd9;
	localparam logic [4:0] cell_h = 5'd16;
	localparam int buf_depth = int'(grid_cols) * int'(grid_rows);

	typedef logic [11:0] buf_addr_t;
	typedef logic [11:0] font_addr_t;
	typedef logic [11:0] font_row_t;
	typedef logic [7:0] scan_code_t;
	typedef logic [7:0] ascii_t;
	typedef logic [6:0] col_t;
	typedef logic [4:0] row_t;

	localparam scan_code_t code_release = 8'hf0;
	localparam scan_code_t code_extend = 8'he0;
	localparam ascii_t ascii_space = 8'h20;

	typedef enum logic [1:0] {rx_idle, rx_data, rx_parity, rx_stop} rx_state_e;
	typedef enum logic [1:0] {dec_normal, dec_released, dec_extended} key_state_e;
	typedef enum logic [1:0] {cmd_put, cmd_newline, cmd_erase} key_cmd_e;

	typedef struct packed {
		key_cmd_e cmd;
		ascii_t ch;
	} key_event_t;

	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
		logic active;
		logic hsync;
		logic vsync;
	} pixel_pos_t;

	// blanked pixel with syncs idle
	localparam pixel_pos_t pos_blank = '{x: 10'd0, y: 10'd0, active: 1'b0, hsync: 1'b1,
		vsync: 1'b1};

endpackage

/* hw/ps2_rx.sv */
`timescale 1ns/1ps

module ps2_rx import term_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic ps2_clk,
	input logic ps2_data,
	output logic scan_valid,
	output scan_code_t scan_code,
	output logic frame_error
);

	logic [1:0] clk_sync;
	logic [1:0] data_sync;
	logic clk_prev;
	logic fall;
	logic rx_bit;
	rx_state_e state;
	logic [2:0] bit_cnt;
	logic start_ok;
	logic parity_ok;
	scan_code_t shift_reg;

	// both lines idle high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clk_sync <= 2'b11;
			data_sync <= 2'b11;
			clk_prev <= 1'b1;
		end else begin
			clk_sync <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_prev <= clk_sync[1];
		end
	end

	assign fall = clk_prev & ~clk_sync[1];
	assign rx_bit = data_sync[1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= rx_idle;
			bit_cnt <= 3'd0;
			start_ok <= 1'b0;
			parity_ok <= 1'b0;
			scan_valid <= 1'b0;
			frame_error <= 1'b0;
		end else begin
			scan_valid <= 1'b0;
			frame_error <= 1'b0;
			if (fall) begin
				unique case (state)
					rx_idle: begin
						start_ok <= ~rx_bit;
						bit_cnt <= 3'd0;
						state <= rx_data;
					end
					rx_data: begin
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7)
							state <= rx_parity;
					end
					rx_parity: begin
						// odd parity over data and parity bit
						parity_ok <= ^{shift_reg, rx_bit};
						state <= rx_stop;
					end
					rx_stop: begin
						if (start_ok && parity_ok && rx_bit)
							scan_valid <= 1'b1;
						else
							frame_error <= 1'b1;
						state <= rx_idle;
					end
				endcase
			end
		end
	end

	// lsb first
	always_ff @(posedge clk) begin
		if (fall && state == rx_data)
			shift_reg <= {rx_bit, shift_reg[7:1]};
	end

	assign scan_code = shift_reg;

	a_one_outcome: assert property (@(posedge clk) disable iff (!rst_n)
		!(scan_valid && frame_error));

endmodule

/* hw/key_decode.sv */
`timescale 1ns/1ps

module key_decode import term_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic scan_valid,
	input scan_code_t scan_code,
	output logic key_valid,
	output key_event_t key_event
);

	key_state_e state;
	logic hit;
	key_event_t ev;

	// set 2 make codes
	always_comb begin
		hit = 1'b1;
		ev.cmd = cmd_put;
		ev.ch = ascii_space;
		unique case (scan_code)
			8'h1c: ev.ch = "A";
			8'h32: ev.ch = "B";
			8'h21: ev.ch = "C";
			8'h23: ev.ch = "D";
			8'h24: ev.ch = "E";
			8'h2b: ev.ch = "F";
			8'h34: ev.ch = "G";
			8'h33: ev.ch = "H";
			8'h43: ev.ch = "I";
			8'h3b: ev.ch = "J";
			8'h42: ev.ch = "K";
			8'h4b: ev.ch = "L";
			8'h3a: ev.ch = "M";
			8'h31: ev.ch = "N";
			8'h44: ev.ch = "O";
			8'h4d: ev.ch = "P";
			8'h15: ev.ch = "Q";
			8'h2d: ev.ch = "R";
			8'h1b: ev.ch = "S";
			8'h2c: ev.ch = "T";
			8'h3c: ev.ch = "U";
			8'h2a: ev.ch = "V";
			8'h1d: ev.ch = "W";
			8'h22: ev.ch = "X";
			8'h35: ev.ch = "Y";
			8'h1a: ev.ch = "Z";
			8'h45: ev.ch = "0";
			8'h16: ev.ch = "1";
			8'h1e: ev.ch = "2";
			8'h26: ev.ch = "3";
			8'h25: ev.ch = "4";
			8'h2e: ev.ch = "5";
			8'h36: ev.ch = "6";
			8'h3d: ev.ch = "7";
			8'h3e: ev.ch = "8";
			8'h46: ev.ch = "9";
			8'h29: ev.ch = ascii_space;
			8'h5a: begin
				ev.cmd = cmd_newline;
				ev.ch = 8'h0a;
			end
			8'h66: begin
				ev.cmd = cmd_erase;
				ev.ch = 8'h08;
			end
			default: hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= dec_normal;
			key_valid <= 1'b0;
		end else begin
			key_valid <= 1'b0;
			if (scan_valid) begin
				unique case (state)
					dec_normal: begin
						if (scan_code == code_release)
							state <= dec_released;
						else if (scan_code == code_extend)
							state <= dec_extended;
						else
							key_valid <= hit;
					end
					// break code byte, dropped
					dec_released: state <= dec_normal;
					dec_extended: begin
						if (scan_code == code_release)
							state <= dec_released;
						else
							state <= dec_normal;
					end
					default: state <= dec_normal;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (scan_valid)
			key_event <= ev;
	end

	a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		key_valid |=> !key_valid);

endmodule

/* hw/text_buffer.sv */
`timescale 1ns/1ps

module text_buffer import term_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic key_valid,
	input key_event_t key_event,
	input buf_addr_t rd_addr,
	output ascii_t rd_char
);

	ascii_t mem [buf_depth];

	col_t cur_col;
	row_t cur_row;
	col_t nxt_col;
	row_t nxt_row;
	row_t row_inc;
	buf_addr_t cur_addr;
	logic clearing;
	buf_addr_t clr_addr;
	logic wr_en;
	buf_addr_t wr_addr;
	ascii_t wr_char;

	assign cur_addr = cur_row * grid_cols + cur_col;
	// no scrolling, wrap to the top row
	assign row_inc = (cur_row == grid_rows - 5'd1) ? 5'd0 : cur_row + 5'd1;

	always_comb begin
		wr_en = 1'b0;
		wr_addr = cur_addr;
		wr_char = ascii_space;
		nxt_col = cur_col;
		nxt_row = cur_row;
		if (clearing) begin
			wr_en = 1'b1;
			wr_addr = clr_addr;
		end else if (key_valid) begin
			unique case (key_event.cmd)
				cmd_put: begin
					wr_en = 1'b1;
					wr_char = key_event.ch;
					if (cur_col == grid_cols - 7'd1) begin
						nxt_col = 7'd0;
						nxt_row = row_inc;
					end else begin
						nxt_col = cur_col + 7'd1;
					end
				end
				cmd_newline: begin
					nxt_col = 7'd0;
					nxt_row = row_inc;
				end
				cmd_erase: begin
					if (cur_col != 7'd0) begin
						nxt_col = cur_col - 7'd1;
						wr_en = 1'b1;
						wr_addr = cur_addr - 12'd1;
					end
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cur_col <= 7'd0;
			cur_row <= 5'd0;
			clearing <= 1'b1;
			clr_addr <= 12'd0;
		end else begin
			cur_col <= nxt_col;
			cur_row <= nxt_row;
			if (clearing) begin
				clr_addr <= clr_addr + 12'd1;
				if (clr_addr == buf_addr_t'(buf_depth - 1))
					clearing <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_char;
	end

	// read before write on a shared address
	always_ff @(posedge clk) begin
		rd_char <= mem[rd_addr];
	end

	a_cursor_in_grid: assert property (@(posedge clk) disable iff (!rst_n)
		cur_col < grid_cols && cur_row < grid_rows);

endmodule

/* hw/vga_timing.sv */
`timescale 1ns/1ps

module vga_timing import term_pkg::*; (
	input logic clk,
	input logic rst_n,
	output pixel_pos_t pos
);

	logic [9:0] h_cnt;
	logic [9:0] v_cnt;
	logic [9:0] h_next;
	logic [9:0] v_next;
	logic active;
	logic hsync;
	logic vsync;

	always_comb begin
		h_next = h_cnt + 10'd1;
		v_next = v_cnt;
		if (h_cnt == h_total - 10'd1) begin
			h_next = 10'd0;
			if (v_cnt == v_total - 10'd1)
				v_next = 10'd0;
			else
				v_next = v_cnt + 10'd1;
		end
	end

	// flags decoded from the next count so they line up with the counters
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			h_cnt <= 10'd0;
			v_cnt <= 10'd0;
			active <= 1'b1;
			hsync <= 1'b1;
			vsync <= 1'b1;
		end else begin
			h_cnt <= h_next;
			v_cnt <= v_next;
			active <= (h_next < h_visible) && (v_next < v_visible);
			hsync <= !((h_next >= h_visible + h_front) &&
				(h_next < h_visible + h_front + h_sync));
			vsync <= !((v_next >= v_visible + v_front) &&
				(v_next < v_visible + v_front + v_sync));
		end
	end

	assign pos.x = h_cnt;
	assign pos.y = v_cnt;
	assign pos.active = active;
	assign pos.hsync = hsync;
	assign pos.vsync = vsync;

	a_h_range: assert property (@(posedge clk) disable iff (!rst_n)
		h_cnt < h_total);

endmodule

/* hw/glyph_render.sv */
`timescale 1ns/1ps

module glyph_render import term_pkg::*; (
	input logic clk,
	input logic rst_n,
	input pixel_pos_t pos,
	output buf_addr_t rd_addr,
	input ascii_t rd_char,
	output font_addr_t font_addr,
	input font_row_t font_row,
	output logic vga_hsync,
	output logic vga_vsync,
	output logic vga_blank_n,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b
);

	col_t cell_col;
	row_t cell_row;
	logic [3:0] in_x;
	logic [3:0] in_y;
	logic in_grid;
	buf_addr_t cell_idx;
	pixel_pos_t pos_s1;
	pixel_pos_t pos_s2;
	logic grid_s1;
	logic grid_s2;
	logic [3:0] cx_s1;
	logic [3:0] cx_s2;
	logic [3:0] cy_s1;
	logic lit;

	// stage 1, cell lookup
	always_comb begin
		cell_col = col_t'(pos.x / cell_w);
		cell_row = row_t'(pos.y / cell_h);
		in_x = 4'(pos.x % cell_w);
		in_y = 4'(pos.y % cell_h);
		// x of 639 falls past column 70
		in_grid = pos.active && (cell_col < grid_cols) && (cell_row < grid_rows);
		cell_idx = cell_row * grid_cols + cell_col;
	end

	assign rd_addr = in_grid ? cell_idx : 12'd0;

	// stage 2, glyph row address
	assign font_addr = grid_s1 ? {rd_char, cy_s1} : 12'd0;

	// stage 3, pixel select
	assign lit = grid_s2 && font_row[cx_s2];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pos_s1 <= pos_blank;
			pos_s2 <= pos_blank;
			grid_s1 <= 1'b0;
			grid_s2 <= 1'b0;
			vga_hsync <= 1'b1;
			vga_vsync <= 1'b1;
			vga_blank_n <= 1'b0;
			vga_r <= 8'd0;
			vga_g <= 8'd0;
			vga_b <= 8'd0;
		end else begin
			pos_s1 <= pos;
			pos_s2 <= pos_s1;
			grid_s1 <= in_grid;
			grid_s2 <= grid_s1;
			vga_hsync <= pos_s2.hsync;
			vga_vsync <= pos_s2.vsync;
			vga_blank_n <= pos_s2.active;
			vga_r <= {8{lit}};
			vga_g <= {8{lit}};
			vga_b <= {8{lit}};
		end
	end

	always_ff @(posedge clk) begin
		cx_s1 <= in_x;
		cy_s1 <= in_y;
		cx_s2 <= cx_s1;
	end

endmodule

/* hw/ps2_terminal.sv */
`timescale 1ns/1ps

module ps2_terminal import term_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic ps2_clk,
	input logic ps2_data,
	output font_addr_t font_addr,
	input font_row_t font_row,
	output logic frame_error,
	output logic vga_hsync,
	output logic vga_vsync,
	output logic vga_blank_n,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b
);

	logic scan_valid;
	scan_code_t scan_code;
	logic key_valid;
	key_event_t key_event;
	buf_addr_t rd_addr;
	ascii_t rd_char;
	pixel_pos_t pos;

	// decode
	ps2_rx rx (
		.clk(clk),
		.rst_n(rst_n),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.scan_valid(scan_valid),
		.scan_code(scan_code),
		.frame_error(frame_error)
	);

	key_decode decode (
		.clk(clk),
		.rst_n(rst_n),
		.scan_valid(scan_valid),
		.scan_code(scan_code),
		.key_valid(key_valid),
		.key_event(key_event)
	);

	// execute
	text_buffer buffer (
		.clk(clk),
		.rst_n(rst_n),
		.key_valid(key_valid),
		.key_event(key_event),
		.rd_addr(rd_addr),
		.rd_char(rd_char)
	);

	// result
	vga_timing timing (
		.clk(clk),
		.rst_n(rst_n),
		.pos(pos)
	);

	glyph_render render (
		.clk(clk),
		.rst_n(rst_n),
		.pos(pos),
		.rd_addr(rd_addr),
		.rd_char(rd_char),
		.font_addr(font_addr),
		.font_row(font_row),
		.vga_hsync(vga_hsync),
		.vga_vsync(vga_vsync),
		.vga_blank_n(vga_blank_n),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b)
	);

endmodule

/* bench/ps2_terminal_tb.sv */
`timescale 1ns/1ps

module ps2_terminal_tb import term_pkg::*; ();

	localparam int clk_half = 5;
	localparam int frame_cycles = int'(h_total) * int'(v_total);
	localparam int watchdog_frames = 8;
	localparam int bit_cycles = 20;
	localparam int frame_gap = 40;
	localparam int pipe_delay = 3;
	localparam int hs_first = 656;
	localparam int hs_last = 751;
	localparam int vs_first = 490;
	localparam int vs_last = 491;
	localparam ascii_t space_char = 8'h20;
	localparam scan_code_t code_enter = 8'h5a;
	localparam scan_code_t code_backspace = 8'h66;

	logic clk;
	logic rst_n;
	logic ps2_clk;
	logic ps2_data;
	font_addr_t font_addr;
	font_row_t font_row;
	logic frame_error;
	logic vga_hsync;
	logic vga_vsync;
	logic vga_blank_n;
	logic [7:0] vga_r;
	logic [7:0] vga_g;
	logic [7:0] vga_b;

	font_row_t font_rom [4096];
	font_addr_t rom_addr;
	ascii_t model_grid [buf_depth];
	int model_col;
	int model_row;
	int cyc;
	logic expect_ferr;
	int ferr_pulses;

	// set 2 make codes, same order as key_chars
	scan_code_t key_codes [37] = '{
		8'h1c, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2b, 8'h34, 8'h33, 8'h43, 8'h3b,
		8'h42, 8'h4b, 8'h3a, 8'h31, 8'h44, 8'h4d, 8'h15, 8'h2d, 8'h1b, 8'h2c,
		8'h3c, 8'h2a, 8'h1d, 8'h22, 8'h35, 8'h1a, 8'h45, 8'h16, 8'h1e, 8'h26,
		8'h25, 8'h2e, 8'h36, 8'h3d, 8'h3e, 8'h46, 8'h29
	};
	string key_chars = "ABCDEFGHIJKLMNOPQRSTUVWXYZ0123456789 ";

	ps2_terminal UUT (
		.clk(clk),
		.rst_n(rst_n),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.font_addr(font_addr),
		.font_row(font_row),
		.frame_error(frame_error),
		.vga_hsync(vga_hsync),
		.vga_vsync(vga_vsync),
		.vga_blank_n(vga_blank_n),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b)
	);

	initial begin
		clk = 1'b0;
		forever #clk_half clk = ~clk;
	end

	// cycles since reset release
	initial begin
		cyc = 0;
		wait (rst_n === 1'b1);
		forever begin
			@(posedge clk);
			cyc = cyc + 1;
		end
	end

	// font ROM with one cycle of latency
	initial begin
		font_row = '0;
		forever begin
			@(negedge clk);
			rom_addr = font_addr;
			@(posedge clk);
			#1;
			font_row = font_rom[rom_addr];
		end
	end

	always @(negedge clk) begin
		if (rst_n && frame_error) begin
			if (expect_ferr)
				ferr_pulses = ferr_pulses + 1;
			else
				report_failure("frame_error pulsed after a PS/2 frame without errors");
		end
	end

	initial begin
		repeat (watchdog_frames * frame_cycles) @(posedge clk);
		report_failure("timeout, the run did not finish within the video frame budget");
	end

	task automatic stop_run();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_failure(string what);
		$display("%s", what);
		stop_run();
	endtask

	task automatic check_pixel(string name, logic [7:0] got, logic [7:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_sync(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s = %b, expected %b", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_addr(string name, font_addr_t got, font_addr_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_count(string name, int got, int exp);
		if (got != exp) begin
			$display("ERROR at %0t: %s = %0d, expected %0d", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic wait_cycles(int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic check_idle();
		check_sync("vga_hsync", vga_hsync, 1'b1);
		check_sync("vga_vsync", vga_vsync, 1'b1);
		check_sync("vga_blank_n", vga_blank_n, 1'b0);
		check_pixel("vga_r", vga_r, 8'h00);
		check_pixel("vga_g", vga_g, 8'h00);
		check_pixel("vga_b", vga_b, 8'h00);
		check_sync("frame_error", frame_error, 1'b0);
	endtask

	// start bit, eight data bits lsb first, odd parity, stop bit
	task automatic send_frame(scan_code_t code, logic bad_parity);
		logic [10:0] bits;
		bits = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
		wait_cycles(1);
		for (int i = 0; i < 11; i++) begin
			ps2_data = bits[i];
			wait_cycles(bit_cycles / 4);
			ps2_clk = 1'b0;
			wait_cycles(bit_cycles / 2);
			ps2_clk = 1'b1;
			wait_cycles(bit_cycles / 4);
		end
		ps2_data = 1'b1;
		wait_cycles(frame_gap);
	endtask

	function automatic ascii_t char_of(scan_code_t code);
		ascii_t ch;
		ch = space_char;
		for (int i = 0; i < 37; i++) begin
			if (key_codes[i] == code)
				ch = ascii_t'(key_chars[i]);
		end
		return ch;
	endfunction

	task automatic model_apply(scan_code_t code);
		int idx;
		idx = model_row * int'(grid_cols) + model_col;
		if (code == code_enter) begin
			model_col = 0;
			model_row = (model_row + 1) % int'(grid_rows);
		end else if (code == code_backspace) begin
			if (model_col > 0) begin
				model_col = model_col - 1;
				model_grid[idx - 1] = space_char;
			end
		end else begin
			model_grid[idx] = char_of(code);
			model_col = model_col + 1;
			if (model_col == int'(grid_cols)) begin
				model_col = 0;
				model_row = (model_row + 1) % int'(grid_rows);
			end
		end
	endtask

	// extended keys never reach the buffer
	task automatic press_key(scan_code_t code, logic extended);
		if (extended)
			send_frame(8'he0, 1'b0);
		send_frame(code, 1'b0);
		if (extended)
			send_frame(8'he0, 1'b0);
		send_frame(8'hf0, 1'b0);
		send_frame(code, 1'b0);
		if (!extended)
			model_apply(code);
	endtask

	task automatic type_random(logic allow_ext);
		int i;
		i = int'($urandom % 37);
		press_key(key_codes[i], allow_ext && ($urandom % 4 == 0));
	endtask

	// one whole video frame against the model grid
	task automatic check_frame();
		int k;
		int x;
		int y;
		logic active;
		logic lit;
		ascii_t ch;
		font_addr_t glyph_addr;
		logic [3:0] glyph_bit;
		@(negedge clk);
		while (cyc < pipe_delay || (cyc - pipe_delay) % frame_cycles != 0)
			@(negedge clk);
		for (int n = 0; n < frame_cycles; n++) begin
			k = (cyc - pipe_delay) % frame_cycles;
			x = k % int'(h_total);
			y = k / int'(h_total);
			active = x < int'(h_visible) && y < int'(v_visible);
			lit = 1'b0;
			if (active && x / int'(cell_w) < int'(grid_cols)) begin
				ch = model_grid[(y / int'(cell_h)) * int'(grid_cols) + x / int'(cell_w)];
				glyph_addr = font_addr_t'(int'(ch) * 16 + y % int'(cell_h));
				glyph_bit = 4'(x % int'(cell_w));
				lit = font_rom[glyph_addr][glyph_bit];
			end
			check_sync("vga_hsync", vga_hsync, !(x >= hs_first && x <= hs_last));
			check_sync("vga_vsync", vga_vsync, !(y >= vs_first && y <= vs_last));
			check_sync("vga_blank_n", vga_blank_n, active);
			check_pixel("vga_r", vga_r, {8{lit}});
			check_pixel("vga_g", vga_g, {8{lit}});
			check_pixel("vga_b", vga_b, {8{lit}});
			@(negedge clk);
		end
	endtask

	initial begin
		rst_n = 1'b0;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		expect_ferr = 1'b0;
		ferr_pulses = 0;
		model_col = 0;
		model_row = 0;
		void'($urandom(32'hdff8c6ac));
		for (int a = 0; a < 4096; a++)
			font_rom[a] = font_row_t'($urandom);
		for (int c = 0; c < buf_depth; c++)
			model_grid[c] = space_char;

		repeat (16) begin
			@(negedge clk);
			check_idle();
			check_addr("font_addr", font_addr, 12'h000);
		end
		@(posedge clk);
		#1;
		rst_n = 1'b1;
		// pipeline still holds reset values
		repeat (2) begin
			@(negedge clk);
			check_idle();
		end

		// clear sweep, one cell per cycle
		wait_cycles(buf_depth + 16);
		check_frame();

		for (int i = 0; i < 100; i++)
			type_random(1'b1);
		check_frame();

		press_key(code_enter, 1'b0);
		press_key(code_backspace, 1'b0);
		repeat (5) type_random(1'b0);
		repeat (2) press_key(code_backspace, 1'b0);
		while (model_row != int'(grid_rows) - 1)
			press_key(code_enter, 1'b0);
		// long line runs off row 29 into row 0
		repeat (75) type_random(1'b0);
		repeat (2) press_key(code_backspace, 1'b0);

		expect_ferr = 1'b1;
		send_frame(key_codes[int'($urandom % 37)], 1'b1);
		for (int t = 0; t < 100 && ferr_pulses == 0; t++)
			@(negedge clk);
		if (ferr_pulses == 0)
			report_failure("no frame_error pulse after a PS/2 frame with bad parity");
		wait_cycles(10);
		expect_ferr = 1'b0;
		check_count("frame_error pulses", ferr_pulses, 1);
		check_frame();

		$display("TEST PASSED");
		$finish;
	end

endmodule

/* ps2_terminal.f */
hw/term_pkg.sv
hw/ps2_rx.sv
hw/key_decode.sv
hw/text_buffer.sv
hw/vga_timing.sv
hw/glyph_render.sv
hw/ps2_terminal.sv
bench/ps2_terminal_tb.sv

/* Makefile */
TOP = ps2_terminal_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f ps2_terminal.f -Mdir obj_dir

run: build
	-obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -qx "TEST PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module ps2_terminal -f ps2_terminal.f

clean:
	rm -rf obj_dir sim.log
